// File: hdl/beacon_cfg.svh
`ifndef BEACON_CFG_SVH
`define BEACON_CFG_SVH

// ------------------------------
// Beacon relay configuration
// ------------------------------

// Character that marks a beacon in the low byte of a word
`define BEACON_CHAR 8'h7E

// Number of transmit words that carry the beacon after one hit
`define BEACON_HOLD_CYCLES 3

// Depth of the rxresetdone synchronizer
`define LANE_SYNC_STAGES 3

// ------------------------------
// Word geometry
// ------------------------------
`define GT_WORD_BYTES 2

`endif

// File: hdl/gt_word_pkg.sv
`default_nettype none

package gt_word_pkg;

  `include "beacon_cfg.svh"

  // ------------------------------
  // Transceiver word views
  // ------------------------------

  // Byte view, hi byte first so lo sits at [7:0]
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } gt_bytes_t;

  // One 16-bit word, read either whole or per byte
  typedef union packed {
    logic [15:0] raw;
    gt_bytes_t   bytes;
  } gt_word_u;

  // One K flag per byte of the word
  typedef logic [`GT_WORD_BYTES-1:0] gt_charisk_t;

endpackage

`default_nettype wire

// File: hdl/rx_lane_monitor.sv
`default_nettype none

`include "beacon_cfg.svh"

module rx_lane_monitor (
  input  logic                     rx_clk,
  input  logic                     rxfsmresetdone,
  input  logic                     rxresetdone_i,
  input  gt_word_pkg::gt_word_u    rx_data_i,
  input  gt_word_pkg::gt_charisk_t rx_charisk_i,
  output gt_word_pkg::gt_word_u    rx_data_o,
  output gt_word_pkg::gt_charisk_t rx_charisk_o,
  output logic                     lane_up_o,
  output logic                     beacon_hit_o
);

  // ------------------------------
  // Reset-done synchronizer
  // ------------------------------

  logic [`LANE_SYNC_STAGES-1:0] sync_q;
  logic                         sync_rst_n;
  logic                         beacon_match;

  // Either reset source drops the lane immediately
  assign sync_rst_n = rxfsmresetdone & rxresetdone_i;

  always_ff @(posedge rx_clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      sync_q <= '0;
    end
    else
    begin
      sync_q <= {sync_q[`LANE_SYNC_STAGES-2:0], rxresetdone_i};
    end
  end

  // Lane is up once the last stage has seen reset-done
  assign lane_up_o = sync_q[`LANE_SYNC_STAGES-1];

  // ------------------------------
  // Received word register
  // ------------------------------

  always_ff @(posedge rx_clk or negedge rxfsmresetdone)
  begin
    if (!rxfsmresetdone)
    begin
      rx_data_o.raw <= '0;
      rx_charisk_o  <= '0;
    end
    else
    begin
      rx_data_o.raw <= rx_data_i.raw;
      rx_charisk_o  <= rx_charisk_i;
    end
  end

  // ------------------------------
  // Beacon detector
  // ------------------------------

  // Only the lo byte carries the beacon
  assign beacon_match = (rx_data_i.bytes.lo == `BEACON_CHAR);

  // One-cycle pulse per matching word, ignored while the lane is down
  always_ff @(posedge rx_clk or negedge rxfsmresetdone)
  begin
    if (!rxfsmresetdone)
    begin
      beacon_hit_o <= 1'b0;
    end
    else
    begin
      beacon_hit_o <= lane_up_o & beacon_match;
    end
  end

endmodule

`default_nettype wire

// File: hdl/beacon_stretcher.sv
`default_nettype none

`include "beacon_cfg.svh"

module beacon_stretcher (
  input  logic rx_clk,
  input  logic rxfsmresetdone,
  input  logic beacon_hit_i,
  output logic beacon_active_o
);

  // Wide enough to hold the full window length
  localparam int CNT_W = $clog2(`BEACON_HOLD_CYCLES + 1);

  logic [CNT_W-1:0] hold_cnt;
  logic             hold_nonzero;

  // ------------------------------
  // Hold counter
  // ------------------------------

  // A hit always reloads, so a second beacon extends the window
  always_ff @(posedge rx_clk or negedge rxfsmresetdone)
  begin
    if (!rxfsmresetdone)
    begin
      hold_cnt <= '0;
    end
    else if (beacon_hit_i)
    begin
      hold_cnt <= CNT_W'(`BEACON_HOLD_CYCLES);
    end
    else if (hold_nonzero)
    begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign hold_nonzero = (hold_cnt != '0);

  // ------------------------------
  // Window flag
  // ------------------------------

  // Registered copy of the nonzero state
  // Lines the window up with the tx word register one cycle later
  always_ff @(posedge rx_clk or negedge rxfsmresetdone)
  begin
    if (!rxfsmresetdone)
    begin
      beacon_active_o <= 1'b0;
    end
    else
    begin
      beacon_active_o <= hold_nonzero;
    end
  end

endmodule

`default_nettype wire

// File: hdl/tx_word_builder.sv
`default_nettype none

`include "beacon_cfg.svh"

module tx_word_builder (
  input  logic                     rx_clk,
  input  logic                     rxfsmresetdone,
  input  logic                     beacon_active_i,
  input  gt_word_pkg::gt_word_u    tx_data_i,
  input  gt_word_pkg::gt_charisk_t tx_charisk_i,
  output gt_word_pkg::gt_word_u    tx_data_o,
  output gt_word_pkg::gt_charisk_t tx_charisk_o
);

  import gt_word_pkg::*;

  gt_word_u tx_word_next;

  // ------------------------------
  // Beacon overwrite
  // ------------------------------

  // Hi byte always passes through untouched
  always_comb
  begin
    tx_word_next = tx_data_i;
    if (beacon_active_i)
    begin
      tx_word_next.bytes.lo = `BEACON_CHAR;
    end
  end

  // ------------------------------
  // Output register
  // ------------------------------

  // K flags are never modified, even when the lo byte is replaced
  always_ff @(posedge rx_clk or negedge rxfsmresetdone)
  begin
    if (!rxfsmresetdone)
    begin
      tx_data_o.raw <= '0;
      tx_charisk_o  <= '0;
    end
    else
    begin
      tx_data_o.raw <= tx_word_next.raw;
      tx_charisk_o  <= tx_charisk_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/beacon_relay_top.sv
`default_nettype none

module beacon_relay_top (
  input  logic                     rx_clk,
  input  logic                     rxfsmresetdone,
  input  logic                     rxresetdone_i,

  // Receive side
  input  gt_word_pkg::gt_word_u    rx_data_i,
  input  gt_word_pkg::gt_charisk_t rx_charisk_i,
  output gt_word_pkg::gt_word_u    rx_data_o,
  output gt_word_pkg::gt_charisk_t rx_charisk_o,
  output logic                     rx_reset_done_o,

  // Transmit side
  input  gt_word_pkg::gt_word_u    tx_data_i,
  input  gt_word_pkg::gt_charisk_t tx_charisk_i,
  output gt_word_pkg::gt_word_u    tx_data_o,
  output gt_word_pkg::gt_charisk_t tx_charisk_o
);

  logic lane_up;
  logic beacon_hit;
  logic beacon_active;

  // ------------------------------
  // Receive side
  // ------------------------------

  rx_lane_monitor u_rx_lane_monitor (
    .rx_clk         (rx_clk),
    .rxfsmresetdone (rxfsmresetdone),
    .rxresetdone_i  (rxresetdone_i),
    .rx_data_i      (rx_data_i),
    .rx_charisk_i   (rx_charisk_i),
    .rx_data_o      (rx_data_o),
    .rx_charisk_o   (rx_charisk_o),
    .lane_up_o      (lane_up),
    .beacon_hit_o   (beacon_hit)
  );

  // Qualified reset-done goes straight out
  assign rx_reset_done_o = lane_up;

  // ------------------------------
  // Hold window
  // ------------------------------

  beacon_stretcher u_beacon_stretcher (
    .rx_clk          (rx_clk),
    .rxfsmresetdone  (rxfsmresetdone),
    .beacon_hit_i    (beacon_hit),
    .beacon_active_o (beacon_active)
  );

  // ------------------------------
  // Transmit side
  // ------------------------------

  // Shares rx_clk, so the window needs no crossing
  tx_word_builder u_tx_word_builder (
    .rx_clk          (rx_clk),
    .rxfsmresetdone  (rxfsmresetdone),
    .beacon_active_i (beacon_active),
    .tx_data_i       (tx_data_i),
    .tx_charisk_i    (tx_charisk_i),
    .tx_data_o       (tx_data_o),
    .tx_charisk_o    (tx_charisk_o)
  );

endmodule

`default_nettype wire

// File: test/beacon_relay_props.sv
`default_nettype none

`include "beacon_cfg.svh"

module beacon_relay_props (
  input logic                                       rx_clk,
  input logic                                       rxfsmresetdone,
  input logic [$clog2(`BEACON_HOLD_CYCLES + 1)-1:0] hold_cnt_i,
  input logic                                       beacon_hit_i,
  input logic                                       beacon_active_i,
  input logic                                       rxresetdone_i,
  input logic                                       lane_up_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Sticky flag read back by the testbench
  logic violation = 1'b0;

  // ------------------------------
  // Hold window
  // ------------------------------

  // A hit loads the full window length on the next edge
  cnt_loads_window: assert property (@(posedge rx_clk) disable iff (!rxfsmresetdone)
    beacon_hit_i |=> hold_cnt_i == `BEACON_HOLD_CYCLES)
  else
  begin
    $error("Hold counter not loaded with the window length: %0d", hold_cnt_i);
    violation = 1'b1;
  end

  // Hit at k loads the counter at k+1 and opens the window at k+2
  active_needs_hit: assert property (@(posedge rx_clk) disable iff (!rxfsmresetdone)
    $rose(beacon_active_i) |-> $past(beacon_hit_i, 2))
  else
  begin
    $error("Beacon window opened without a preceding hit");
    violation = 1'b1;
  end

  // ------------------------------
  // Lane flag
  // ------------------------------

  lane_needs_done: assert property (@(posedge rx_clk) disable iff (!rxfsmresetdone)
    !rxresetdone_i |-> !lane_up_i)
  else
  begin
    $error("Lane up while rxresetdone is low");
    violation = 1'b1;
  end

  lane_after_sync: assert property (@(posedge rx_clk) disable iff (!rxfsmresetdone)
    lane_up_i |-> $past(rxresetdone_i, `LANE_SYNC_STAGES))
  else
  begin
    $error("Lane up before the synchronizer could pass reset-done");
    violation = 1'b1;
  end

endmodule

// Unused inputs of each instance are tied off
bind beacon_stretcher beacon_relay_props u_props (
  .rx_clk          (rx_clk),
  .rxfsmresetdone  (rxfsmresetdone),
  .hold_cnt_i      (hold_cnt),
  .beacon_hit_i    (beacon_hit_i),
  .beacon_active_i (beacon_active_o),
  .rxresetdone_i   (1'b1),
  .lane_up_i       (1'b0)
);

bind rx_lane_monitor beacon_relay_props u_props (
  .rx_clk          (rx_clk),
  .rxfsmresetdone  (rxfsmresetdone),
  .hold_cnt_i      ('0),
  .beacon_hit_i    (1'b0),
  .beacon_active_i (1'b0),
  .rxresetdone_i   (rxresetdone_i),
  .lane_up_i       (lane_up_o)
);

`default_nettype wire

// File: test/beacon_relay_tb.sv
`default_nettype none

`include "beacon_cfg.svh"

module beacon_relay_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import gt_word_pkg::*;

  localparam int NUM_ROWS     = 34;
  localparam int RESET_CYCLES = 8;
  localparam int LANE_TIMEOUT = 10;

  // One stimulus row per rx_clk cycle
  typedef struct packed {
    logic        rd;
    logic [7:0]  rx_lo;
    logic        tx_rand;
    logic [15:0] tx_word;
    logic        exp_lane;
    logic        exp_win;
  } row_t;

  row_t        stim_rows [NUM_ROWS];
  int          row_cnt;
  integer      seed;
  int          lane_cycles;

  logic        rx_clk;
  logic        rxfsmresetdone;
  logic        rxresetdone_i;
  gt_word_u    rx_data_i;
  gt_charisk_t rx_charisk_i;
  gt_word_u    tx_data_i;
  gt_charisk_t tx_charisk_i;
  gt_word_u    rx_data_o;
  gt_charisk_t rx_charisk_o;
  gt_word_u    tx_data_o;
  gt_charisk_t tx_charisk_o;
  logic        rx_reset_done_o;

  beacon_relay_top DUT (
    .rx_clk          (rx_clk),
    .rxfsmresetdone  (rxfsmresetdone),
    .rxresetdone_i   (rxresetdone_i),
    .rx_data_i       (rx_data_i),
    .rx_charisk_i    (rx_charisk_i),
    .rx_data_o       (rx_data_o),
    .rx_charisk_o    (rx_charisk_o),
    .rx_reset_done_o (rx_reset_done_o),
    .tx_data_i       (tx_data_i),
    .tx_charisk_i    (tx_charisk_i),
    .tx_data_o       (tx_data_o),
    .tx_charisk_o    (tx_charisk_o)
  );

  initial
  begin
    rx_clk = 1'b0;
    forever #50 rx_clk = ~rx_clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure("Output mismatch");
    end
  endtask

  function automatic logic props_violated();
    return DUT.u_beacon_stretcher.u_props.violation ||
           DUT.u_rx_lane_monitor.u_props.violation;
  endfunction

  task automatic check_props();
    assert (!props_violated())
    else
    begin
      stop_on_failure("A bound property on the stretcher or lane monitor failed");
    end
  endtask

  task automatic check_zero();
    check_value("rx_reset_done_o", rx_reset_done_o, 32'h0);
    check_value("rx_data_o", rx_data_o.raw, 32'h0);
    check_value("rx_charisk_o", rx_charisk_o, 32'h0);
    check_value("tx_data_o", tx_data_o.raw, 32'h0);
    check_value("tx_charisk_o", tx_charisk_o, 32'h0);
  endtask

  task automatic add_row(input logic rd, input logic [7:0] rx_lo, input logic tx_rand,
                         input logic [15:0] tx_word, input logic exp_lane,
                         input logic exp_win);
    stim_rows[row_cnt] = '{rd, rx_lo, tx_rand, tx_word, exp_lane, exp_win};
    row_cnt++;
  endtask

  task automatic fill_rows();
    row_cnt = 0;
    //      rd    rx lo  rnd   tx word   lane  win
    // Beacons with the lane down, then lane coming up
    add_row(1'b0, 8'h7E, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b0, 8'h11, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b0, 8'h7E, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b1, 8'h22, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b1, 8'h7E, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b1, 8'h33, 1'b1, 16'h0000, 1'b1, 1'b0);
    add_row(1'b1, 8'h44, 1'b1, 16'h0000, 1'b1, 1'b0);
    // Lone beacon
    add_row(1'b1, 8'h7E, 1'b0, 16'hA101, 1'b1, 1'b0);
    add_row(1'b1, 8'h55, 1'b0, 16'hA102, 1'b1, 1'b0);
    add_row(1'b1, 8'h66, 1'b0, 16'hA103, 1'b1, 1'b0);
    add_row(1'b1, 8'h01, 1'b0, 16'hA104, 1'b1, 1'b1);
    add_row(1'b1, 8'h02, 1'b0, 16'hA105, 1'b1, 1'b1);
    add_row(1'b1, 8'h03, 1'b0, 16'hA106, 1'b1, 1'b1);
    add_row(1'b1, 8'h04, 1'b0, 16'hA107, 1'b1, 1'b0);
    add_row(1'b1, 8'h05, 1'b0, 16'hA108, 1'b1, 1'b0);
    // Two beacons two cycles apart
    add_row(1'b1, 8'h7E, 1'b0, 16'hB201, 1'b1, 1'b0);
    add_row(1'b1, 8'h10, 1'b0, 16'hB202, 1'b1, 1'b0);
    add_row(1'b1, 8'h7E, 1'b0, 16'hB203, 1'b1, 1'b0);
    add_row(1'b1, 8'h20, 1'b0, 16'hB204, 1'b1, 1'b1);
    add_row(1'b1, 8'h30, 1'b0, 16'hB205, 1'b1, 1'b1);
    add_row(1'b1, 8'h40, 1'b0, 16'hB206, 1'b1, 1'b1);
    add_row(1'b1, 8'h50, 1'b0, 16'hB207, 1'b1, 1'b1);
    add_row(1'b1, 8'h60, 1'b0, 16'hB208, 1'b1, 1'b1);
    add_row(1'b1, 8'h70, 1'b0, 16'hB209, 1'b1, 1'b0);
    add_row(1'b1, 8'h80, 1'b0, 16'hB20A, 1'b1, 1'b0);
    // Lane drop and relock, beacons ignored until up again
    add_row(1'b0, 8'h7E, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b0, 8'h7E, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b1, 8'h7E, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b1, 8'h7E, 1'b1, 16'h0000, 1'b0, 1'b0);
    add_row(1'b1, 8'h7E, 1'b1, 16'h0000, 1'b1, 1'b0);
    add_row(1'b1, 8'h12, 1'b1, 16'h0000, 1'b1, 1'b0);
    add_row(1'b1, 8'h13, 1'b1, 16'h0000, 1'b1, 1'b0);
    add_row(1'b1, 8'h14, 1'b1, 16'h0000, 1'b1, 1'b0);
    add_row(1'b1, 8'h15, 1'b1, 16'h0000, 1'b1, 1'b0);
  endtask

  task automatic drive_noise();
    rx_data_i.raw = $random(seed);
    rx_charisk_i  = $random(seed);
    tx_data_i.raw = $random(seed);
    tx_charisk_i  = $random(seed);
  endtask

  task automatic drive_row(input row_t r);
    logic [31:0] rnd;
    rnd = $random(seed);
    rxresetdone_i      = r.rd;
    rx_data_i.bytes.hi = rnd[15:8];
    rx_data_i.bytes.lo = r.rx_lo;
    rx_charisk_i       = rnd[1:0];
    tx_charisk_i       = rnd[3:2];
    tx_data_i.raw      = r.tx_rand ? rnd[31:16] : r.tx_word;
    // Filler must not look like an overwrite
    if (r.tx_rand && tx_data_i.bytes.lo == `BEACON_CHAR)
    begin
      tx_data_i.bytes.lo = `BEACON_CHAR ^ 8'h01;
    end
  endtask

  // Inputs are still those sampled at the last edge
  task automatic check_row(input row_t r);
    gt_word_u exp_tx;
    exp_tx = tx_data_i;
    if (r.exp_win)
    begin
      exp_tx.bytes.lo = `BEACON_CHAR;
    end
    check_value("rx_reset_done_o", rx_reset_done_o, r.exp_lane);
    check_value("rx_data_o", rx_data_o.raw, rx_data_i.raw);
    check_value("rx_charisk_o", rx_charisk_o, rx_charisk_i);
    check_value("tx_data_o", tx_data_o.raw, exp_tx.raw);
    check_value("tx_charisk_o", tx_charisk_o, tx_charisk_i);
    check_props();
  endtask

  task automatic wait_lane_up(output int cycles);
    cycles = 0;
    while (rx_reset_done_o !== 1'b1 && cycles < LANE_TIMEOUT)
    begin
      @(posedge rx_clk);
      #1;
      cycles++;
    end
    assert (rx_reset_done_o === 1'b1)
    else
    begin
      stop_on_failure($sformatf("Lane did not come up within %0d cycles", LANE_TIMEOUT));
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial
  begin
    seed           = 32'hae84_0e26;
    rxfsmresetdone = 1'b0;
    rxresetdone_i  = 1'b0;
    rx_data_i      = '0;
    rx_charisk_i   = '0;
    tx_data_i      = '0;
    tx_charisk_i   = '0;
    fill_rows();

    // Noise on the data inputs must not reach any register
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(posedge rx_clk);
      #1;
      check_zero();
      @(negedge rx_clk);
      drive_noise();
    end
    rxfsmresetdone = 1'b1;
    #1;
    check_zero();

    for (int i = 0; i < row_cnt; i++)
    begin
      @(negedge rx_clk);
      drive_row(stim_rows[i]);
      // Async clear of the synchronizer
      if (!stim_rows[i].rd)
      begin
        #1;
        check_value("rx_reset_done_o", rx_reset_done_o, 32'h0);
      end
      @(posedge rx_clk);
      #1;
      check_row(stim_rows[i]);
    end

    // Relock once more and count the edges
    @(negedge rx_clk);
    rxresetdone_i      = 1'b0;
    rx_data_i.bytes.lo = 8'h00;
    #1;
    check_value("rx_reset_done_o", rx_reset_done_o, 32'h0);
    @(negedge rx_clk);
    rxresetdone_i = 1'b1;
    wait_lane_up(lane_cycles);
    assert (lane_cycles == `LANE_SYNC_STAGES)
    else
    begin
      stop_on_failure($sformatf("Lane came up after %0d edges instead of %0d",
                                lane_cycles, `LANE_SYNC_STAGES));
    end

    if (props_violated())
    begin
      stop_on_failure("A bound property failed during the relock sequence");
    end
    else
    begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/gt_word_pkg.sv
hdl/rx_lane_monitor.sv
hdl/beacon_stretcher.sv
hdl/tx_word_builder.sv
hdl/beacon_relay_top.sv
test/beacon_relay_props.sv
test/beacon_relay_tb.sv

// File: Bender.yml
package:
  name: beacon_relay

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gt_word_pkg.sv
      - hdl/rx_lane_monitor.sv
      - hdl/beacon_stretcher.sv
      - hdl/tx_word_builder.sv
      - hdl/beacon_relay_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/beacon_relay_props.sv
      - test/beacon_relay_tb.sv
